//--- Makefile
# Verilator build and run of the slide unit testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing run"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -j 0 --top-module tb_sldu -Mdir obj_dir -f build.f
	@./obj_dir/Vtb_sldu > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Testbench failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
sldu_pkg.sv
sldu_if.sv
sldu_decode.sv
sldu_execute.sv
sldu_result.sv
sldu_top.sv
tb_sldu.sv

//--- sldu_decode.sv
/*
 * Instruction queue of the slide unit
 * Holds up to two requests and prepares the issue fields of the oldest one
 */

`timescale 1ns/1ps

module sldu_decode (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer side
  input  sldu_pkg::slide_req_t req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  // Towards execute
  sldu_issue_if.source         issue
);

  //////////////////////////////
  // Instruction queue
  //////////////////////////////

  // Stored requests
  sldu_pkg::slide_req_t queue_q [sldu_pkg::InsnQueueDepth];

  // Accept and issue pointers, plus the number of queued requests
  logic [$clog2(sldu_pkg::InsnQueueDepth)-1:0] accept_pnt_q;
  logic [$clog2(sldu_pkg::InsnQueueDepth)-1:0] issue_pnt_q;
  logic [$clog2(sldu_pkg::InsnQueueDepth):0]   cnt_q;

  logic accept;
  logic issue_fire;

  // Room for one more request
  assign req_ready_o = (cnt_q < sldu_pkg::InsnQueueDepth);
  assign accept      = req_valid_i && req_ready_o;
  assign issue_fire  = issue.valid && issue.ready;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt_q] <= req_i;
    end
  end

  // Pointers wrap on their own with a power-of-two depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      cnt_q        <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_fire) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      case ({accept, issue_fire})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  //////////////////////////////
  // Issue preparation
  //////////////////////////////

  sldu_pkg::slide_req_t head;
  sldu_pkg::vlen_t      byte_off;
  sldu_pkg::vlen_t      total;
  sldu_pkg::vaddr_t     vd_base;

  always_comb begin
    head = queue_q[issue_pnt_q];

    // Element counts turned into byte counts
    byte_off = sldu_pkg::vlen_t'(head.offset << head.vsew);
    total    = sldu_pkg::vlen_t'(head.vl << head.vsew);
    // First word of the destination register
    vd_base  = sldu_pkg::vaddr_t'(head.vd) << $clog2(sldu_pkg::WordsPerVreg);

    issue.valid = (cnt_q != '0);
    issue.op    = head.op;
    issue.id    = head.id;

    if (head.op == sldu_pkg::SLIDE_UP) begin
      // Read from the stream start, write from the offset on
      issue.in_start  = '0;
      issue.out_start = sldu_pkg::boff_t'(byte_off);
      issue.bytes     = total - byte_off;
      issue.base_addr = vd_base +
                        sldu_pkg::vaddr_t'(byte_off >> $clog2(sldu_pkg::WordBytes));
    end else begin
      // Skip the offset bytes of the first word, write from byte 0
      issue.in_start  = sldu_pkg::boff_t'(byte_off);
      issue.out_start = '0;
      issue.bytes     = total;
      issue.base_addr = vd_base;
    end
  end

  // Sequencer contract on every accepted request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (req_i.vl != '0) && (req_i.offset < req_i.vl))
    else $error("slide request with offset not below vl");

endmodule

//--- sldu_execute.sv
/*
 * Slide FSM of the slide unit
 * Realigns operand bytes into result words and pushes them to the result queue
 */

`timescale 1ns/1ps

module sldu_execute (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Prepared instruction
  sldu_issue_if.sink      issue,
  // Operand stream
  input  sldu_pkg::word_t operand_i,
  input  logic            operand_valid_i,
  output logic            operand_ready_o,
  // Result words
  sldu_res_if.source      res
);

  sldu_pkg::slide_state_e state_d, state_q;

  // Byte pointers in the operand word and in the output word
  sldu_pkg::bptr_t  in_pnt_d, in_pnt_q;
  sldu_pkg::bptr_t  out_pnt_d, out_pnt_q;
  // Bytes still to be written
  sldu_pkg::vlen_t  cnt_d, cnt_q;
  // Address and id of the word being assembled
  sldu_pkg::vaddr_t addr_d, addr_q;
  sldu_pkg::vid_t   id_d, id_q;
  // Output word under assembly
  sldu_pkg::word_t  wdata_d, wdata_q;
  sldu_pkg::strb_t  be_d, be_q;

  sldu_pkg::bptr_t  in_left, out_left, run_max, byte_cnt;
  sldu_pkg::boff_t  in_idx, out_idx;
  sldu_pkg::word_t  word_asm;
  sldu_pkg::strb_t  be_asm;
  logic             step;
  logic             finish;

  //////////////////////////////
  // Step size
  //////////////////////////////

  assign issue.ready = (state_q == sldu_pkg::SLIDE_IDLE);
  // Move only with an operand at hand and room in the result queue
  assign step        = (state_q == sldu_pkg::SLIDE_RUN) && operand_valid_i && res.ready;

  assign in_left  = sldu_pkg::bptr_t'(sldu_pkg::WordBytes) - in_pnt_q;
  assign out_left = sldu_pkg::bptr_t'(sldu_pkg::WordBytes) - out_pnt_q;
  assign run_max  = (in_left < out_left) ? in_left : out_left;
  // Clamp by the bytes left in the instruction
  assign byte_cnt = (cnt_q < sldu_pkg::vlen_t'(run_max)) ? sldu_pkg::bptr_t'(cnt_q) : run_max;
  assign finish   = (cnt_q == sldu_pkg::vlen_t'(byte_cnt));

  //////////////////////////////
  // Slide FSM
  //////////////////////////////

  always_comb begin
    state_d   = state_q;
    in_pnt_d  = in_pnt_q;
    out_pnt_d = out_pnt_q;
    cnt_d     = cnt_q;
    addr_d    = addr_q;
    id_d      = id_q;
    wdata_d   = wdata_q;
    be_d      = be_q;
    word_asm  = wdata_q;
    be_asm    = be_q;
    in_idx    = '0;
    out_idx   = '0;

    operand_ready_o = 1'b0;
    res.valid       = 1'b0;

    case (state_q)
      sldu_pkg::SLIDE_IDLE: begin
        if (issue.valid) begin
          state_d   = sldu_pkg::SLIDE_RUN;
          // Down slides skip into the stream, up slides skip into the output
          in_pnt_d  = (issue.op == sldu_pkg::SLIDE_DOWN) ? sldu_pkg::bptr_t'(issue.in_start) : '0;
          out_pnt_d = (issue.op == sldu_pkg::SLIDE_UP) ? sldu_pkg::bptr_t'(issue.out_start) : '0;
          cnt_d     = issue.bytes;
          addr_d    = issue.base_addr;
          id_d      = issue.id;
          wdata_d   = '0;
          be_d      = '0;
        end
      end

      sldu_pkg::SLIDE_RUN: begin
        if (step) begin
          // Copy a run of byte_cnt bytes
          for (int b = 0; b < sldu_pkg::WordBytes; b++) begin
            in_idx  = sldu_pkg::boff_t'(in_pnt_q) + sldu_pkg::boff_t'(b);
            out_idx = sldu_pkg::boff_t'(out_pnt_q) + sldu_pkg::boff_t'(b);
            if (sldu_pkg::bptr_t'(b) < byte_cnt) begin
              word_asm[out_idx*sldu_pkg::ByteBits +: sldu_pkg::ByteBits] =
                operand_i[in_idx*sldu_pkg::ByteBits +: sldu_pkg::ByteBits];
              be_asm[out_idx] = 1'b1;
            end
          end

          wdata_d   = word_asm;
          be_d      = be_asm;
          in_pnt_d  = in_pnt_q + byte_cnt;
          out_pnt_d = out_pnt_q + byte_cnt;
          cnt_d     = cnt_q - sldu_pkg::vlen_t'(byte_cnt);

          // Operand word used up, or nothing more needed from it
          if (in_pnt_d == sldu_pkg::bptr_t'(sldu_pkg::WordBytes) || finish) begin
            in_pnt_d        = '0;
            operand_ready_o = 1'b1;
          end

          // Output word full or instruction over
          if (out_pnt_d == sldu_pkg::bptr_t'(sldu_pkg::WordBytes) || finish) begin
            res.valid = 1'b1;
            out_pnt_d = '0;
            addr_d    = addr_q + 1'b1;
            wdata_d   = '0;
            be_d      = '0;
          end

          if (finish) begin
            state_d = sldu_pkg::SLIDE_IDLE;
          end
        end
      end

      default: state_d = sldu_pkg::SLIDE_IDLE;
    endcase

    res.payload.addr  = addr_q;
    res.payload.id    = id_q;
    res.payload.wdata = word_asm;
    res.payload.be    = be_asm;
    res.payload.last  = finish;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= sldu_pkg::SLIDE_IDLE;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      cnt_q     <= '0;
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
      cnt_q     <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q  <= addr_d;
    id_q    <= id_d;
    wdata_q <= wdata_d;
    be_q    <= be_d;
  end

  // Pointers stay inside one word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_pnt_q <= sldu_pkg::bptr_t'(sldu_pkg::WordBytes)) &&
    (out_pnt_q <= sldu_pkg::bptr_t'(sldu_pkg::WordBytes)))
    else $error("slide byte pointer beyond word size");

endmodule

//--- sldu_if.sv
/*
 * Internal links of the slide unit
 * sldu_issue_if carries a prepared instruction from decode to execute
 * sldu_res_if carries result words from execute to the result queue
 */

`timescale 1ns/1ps

interface sldu_issue_if;

  logic               valid;
  logic               ready;
  sldu_pkg::sldu_op_e op;
  // First byte read from the stream and first byte written in the output word
  sldu_pkg::boff_t    in_start;
  sldu_pkg::boff_t    out_start;
  // Bytes written by this instruction
  sldu_pkg::vlen_t    bytes;
  // Address of the first result word
  sldu_pkg::vaddr_t   base_addr;
  sldu_pkg::vid_t     id;

  modport source (output valid, op, in_start, out_start, bytes, base_addr, id,
                  input  ready);
  modport sink   (input  valid, op, in_start, out_start, bytes, base_addr, id,
                  output ready);

endinterface

interface sldu_res_if;

  logic                   valid;
  logic                   ready;
  sldu_pkg::res_payload_t payload;

  modport source (output valid, payload, input  ready);
  modport sink   (input  valid, payload, output ready);

endinterface

//--- sldu_pkg.sv
/*
 * Shared definitions of the slide unit
 * Datapath widths, queue depths and register-file geometry
 * Opcode, element-width and FSM state enums
 * Request and result payload structs
 */

package sldu_pkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////

  // One 64-bit datapath word of eight bytes
  localparam int unsigned WordBytes = 8;
  localparam int unsigned ByteBits  = 8;
  localparam int unsigned ElemBits  = WordBytes * ByteBits;

  // Vector register size and its word count
  localparam int unsigned VregBytes    = 256;
  localparam int unsigned WordsPerVreg = VregBytes / WordBytes;

  // Byte counts up to a full register
  localparam int unsigned VlenBits = 9;
  // Register index times WordsPerVreg plus the word index
  localparam int unsigned AddrBits = 10;

  // Instruction ids
  localparam int unsigned NrIds  = 8;
  localparam int unsigned IdBits = $clog2(NrIds);

  // Queue depths
  localparam int unsigned InsnQueueDepth   = 2;
  localparam int unsigned ResultQueueDepth = 2;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [ElemBits-1:0]                       word_t;
  typedef logic [WordBytes-1:0]                      strb_t;
  typedef logic [AddrBits-1:0]                       vaddr_t;
  typedef logic [VlenBits-1:0]                       vlen_t;
  typedef logic [IdBits-1:0]                         vid_t;
  typedef logic [AddrBits-$clog2(WordsPerVreg)-1:0]  vreg_t;
  // Byte offset inside a word, and a byte pointer that may reach WordBytes
  typedef logic [$clog2(WordBytes)-1:0]              boff_t;
  typedef logic [$clog2(WordBytes):0]                bptr_t;

  typedef enum logic {SLIDE_UP, SLIDE_DOWN} sldu_op_e;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vsew_e;

  typedef enum logic {SLIDE_IDLE, SLIDE_RUN} slide_state_e;

  // Request from the sequencer, vl and offset counted in elements
  typedef struct packed {
    sldu_op_e op;
    vsew_e    vsew;
    vlen_t    vl;
    vlen_t    offset;
    vreg_t    vd;
    vid_t     id;
  } slide_req_t;

  // One result word on its way to the register file
  typedef struct packed {
    vaddr_t addr;
    vid_t   id;
    word_t  wdata;
    strb_t  be;
    logic   last;
  } res_payload_t;

endpackage

//--- sldu_result.sv
/*
 * Result queue of the slide unit
 * Register-file write port and the done report on the last word
 */

`timescale 1ns/1ps

module sldu_result (
  input  logic             clk_i,
  input  logic             rst_ni,
  // From execute
  sldu_res_if.sink         res,
  // Register-file write port
  output logic             res_valid_o,
  output sldu_pkg::vaddr_t res_addr_o,
  output sldu_pkg::vid_t   res_id_o,
  output sldu_pkg::word_t  res_wdata_o,
  output sldu_pkg::strb_t  res_be_o,
  input  logic             res_ready_i,
  // Done report
  output logic             done_o,
  output sldu_pkg::vid_t   done_id_o
);

  //////////////////////////////
  // Result queue
  //////////////////////////////

  sldu_pkg::res_payload_t queue_q [sldu_pkg::ResultQueueDepth];

  // Write and read pointers, plus the number of stored words
  logic [$clog2(sldu_pkg::ResultQueueDepth)-1:0] wr_pnt_q;
  logic [$clog2(sldu_pkg::ResultQueueDepth)-1:0] rd_pnt_q;
  logic [$clog2(sldu_pkg::ResultQueueDepth):0]   cnt_q;

  sldu_pkg::res_payload_t head;
  logic                   push;
  logic                   pop;

  // Accept from execute unless full
  assign res.ready = (cnt_q < sldu_pkg::ResultQueueDepth);
  assign push      = res.valid && res.ready;

  // Oldest word goes to the register file
  assign head        = queue_q[rd_pnt_q];
  assign res_valid_o = (cnt_q != '0);
  assign res_addr_o  = head.addr;
  assign res_id_o    = head.id;
  assign res_wdata_o = head.wdata;
  assign res_be_o    = head.be;
  assign pop         = res_valid_o && res_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_pnt_q] <= res.payload;
    end
  end

  //////////////////////////////
  // Pointers and commit
  //////////////////////////////

  // Pointers wrap on their own with a power-of-two depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q  <= '0;
      rd_pnt_q  <= '0;
      cnt_q     <= '0;
      done_o    <= 1'b0;
      done_id_o <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase

      // Last word written back means the instruction is done
      done_o <= pop && head.last;
      if (pop) begin
        done_id_o <= head.id;
      end
    end
  end

  // A stalled write keeps its request and payload
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (res_valid_o && !res_ready_i) |=> res_valid_o && $stable(head))
    else $error("result word changed while stalled");

endmodule

//--- sldu_top.sv
/*
 * Slide unit top level
 * Decode, execute and result stages joined by their links
 */

`timescale 1ns/1ps

module sldu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Requests from the sequencer
  input  sldu_pkg::slide_req_t req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  // Source operand stream
  input  sldu_pkg::word_t      operand_i,
  input  logic                 operand_valid_i,
  output logic                 operand_ready_o,
  // Register-file write port
  output logic                 res_valid_o,
  output sldu_pkg::vaddr_t     res_addr_o,
  output sldu_pkg::vid_t       res_id_o,
  output sldu_pkg::word_t      res_wdata_o,
  output sldu_pkg::strb_t      res_be_o,
  input  logic                 res_ready_i,
  // Done report
  output logic                 done_o,
  output sldu_pkg::vid_t       done_id_o
);

  // Links between the stages
  sldu_issue_if issue_if ();
  sldu_res_if   res_if ();

  sldu_decode i_sldu_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .issue       (issue_if.source)
  );

  sldu_execute i_sldu_execute (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue           (issue_if.sink),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .res             (res_if.source)
  );

  sldu_result i_sldu_result (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .res         (res_if.sink),
    .res_valid_o (res_valid_o),
    .res_addr_o  (res_addr_o),
    .res_id_o    (res_id_o),
    .res_wdata_o (res_wdata_o),
    .res_be_o    (res_be_o),
    .res_ready_i (res_ready_i),
    .done_o      (done_o),
    .done_id_o   (done_id_o)
  );

endmodule

//--- tb_sldu.sv
/*
 * Testbench of the slide unit
 * Random requests, operand stream and write-port back-pressure
 * Byte-level model of the slide stream rule and a result checker
 */

`timescale 1ns/1ps

module tb_sldu;

  logic                 clk_i;
  logic                 rst_ni;
  sldu_pkg::slide_req_t req_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  sldu_pkg::word_t      operand_i;
  logic                 operand_valid_i;
  logic                 operand_ready_o;
  logic                 res_valid_o;
  sldu_pkg::vaddr_t     res_addr_o;
  sldu_pkg::vid_t       res_id_o;
  sldu_pkg::word_t      res_wdata_o;
  sldu_pkg::strb_t      res_be_o;
  logic                 res_ready_i;
  logic                 done_o;
  sldu_pkg::vid_t       done_id_o;

  // Random source and run statistics
  int seed;
  int error_count;
  int check_count;
  int timeout_count;
  int word_count;
  int accept_count;
  int done_count;
  int next_id;
  // Handshake rates in percent
  int ready_pct;
  int valid_pct;

  // Model state
  sldu_pkg::slide_req_t   req_q [$];
  sldu_pkg::word_t        op_q [$];
  sldu_pkg::res_payload_t exp_q [$];
  sldu_pkg::res_payload_t act_q [$];
  sldu_pkg::vid_t         done_ids [$];
  // Word handed over at the last edge, word held under stall, word on the port now
  sldu_pkg::res_payload_t pend;
  sldu_pkg::res_payload_t held;
  sldu_pkg::res_payload_t seen;
  logic                   pend_valid;
  logic                   stall_prev;
  // Offered operand word not yet taken by the DUT
  logic                   operand_hold;

  sldu_top i_sldu_top (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  //////////////////////////////
  // Model and checker
  //////////////////////////////

  task automatic compare_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // Operand words one instruction consumes
  function automatic int stream_words(input sldu_pkg::slide_req_t r);
    int boff;
    int total;
    boff  = int'(r.offset) << int'(r.vsew);
    total = int'(r.vl) << int'(r.vsew);
    if (r.op == sldu_pkg::SLIDE_UP) begin
      stream_words = (total - boff + 7) / 8;
    end else begin
      stream_words = (boff % 8 + total + 7) / 8;
    end
  endfunction

  // Destination bytes from the stream, then cut into result words
  task automatic expand_instruction();
    sldu_pkg::slide_req_t   r;
    sldu_pkg::res_payload_t p;
    sldu_pkg::word_t        src [33];
    logic [7:0]             dest [256];
    bit                     written [256];
    int                     boff;
    int                     total;
    int                     first;
    int                     j;
    r     = req_q.pop_front();
    boff  = int'(r.offset) << int'(r.vsew);
    total = int'(r.vl) << int'(r.vsew);
    for (int w = 0; w < stream_words(r); w++) begin
      src[w] = op_q.pop_front();
    end
    for (int k = 0; k < sldu_pkg::VregBytes; k++) begin
      dest[k]    = '0;
      written[k] = 1'b0;
    end
    first = (r.op == sldu_pkg::SLIDE_UP) ? boff : 0;
    for (int k = first; k < total; k++) begin
      // Stream byte that lands on destination byte k
      j          = (r.op == sldu_pkg::SLIDE_UP) ? k - boff : boff % 8 + k;
      dest[k]    = src[j / 8][(j % 8) * 8 +: 8];
      written[k] = 1'b1;
    end
    for (int w = first / 8; w <= (total - 1) / 8; w++) begin
      p.addr  = sldu_pkg::vaddr_t'(int'(r.vd) * sldu_pkg::WordsPerVreg + w);
      p.id    = r.id;
      p.last  = (w == (total - 1) / 8);
      p.wdata = '0;
      p.be    = '0;
      for (int b = 0; b < sldu_pkg::WordBytes; b++) begin
        if (written[w * 8 + b]) begin
          p.wdata[b * 8 +: 8] = dest[w * 8 + b];
          p.be[b]             = 1'b1;
        end
      end
      exp_q.push_back(p);
    end
  endtask

  // Pair observed words with modelled ones in order
  task automatic match_results();
    sldu_pkg::res_payload_t a;
    sldu_pkg::res_payload_t e;
    while (act_q.size() > 0 && exp_q.size() > 0) begin
      a = act_q.pop_front();
      e = exp_q.pop_front();
      compare_value("res_addr_o", a.addr, e.addr);
      compare_value("res_id_o", a.id, e.id);
      compare_value("res_wdata_o", a.wdata, e.wdata);
      compare_value("res_be_o", a.be, e.be);
      compare_value("done_o after word", a.last, e.last);
      word_count++;
    end
  endtask

  // Sampled at the falling edge, away from the rising-edge updates
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // A done pulse marks the word handed over one edge before as last
      if (pend_valid) begin
        pend.last = done_o;
        if (done_o) begin
          if (done_ids.size() == 0) begin
            error_count++;
            $display("ERROR at %0t ns: done pulse with no instruction outstanding", $time);
          end else begin
            compare_value("done_id_o order", done_id_o, done_ids.pop_front());
          end
          done_count++;
        end
        act_q.push_back(pend);
        pend_valid = 1'b0;
      end else if (done_o) begin
        error_count++;
        done_count++;
        $display("ERROR at %0t ns: done pulse without a result word before it", $time);
      end

      seen.addr  = res_addr_o;
      seen.id    = res_id_o;
      seen.wdata = res_wdata_o;
      seen.be    = res_be_o;
      seen.last  = 1'b0;

      // Stalled word stays put
      if (stall_prev) begin
        compare_value("res_valid_o held", res_valid_o, 1'b1);
        compare_value("res_addr_o held", seen.addr, held.addr);
        compare_value("res_id_o held", seen.id, held.id);
        compare_value("res_wdata_o held", seen.wdata, held.wdata);
        compare_value("res_be_o held", seen.be, held.be);
      end

      // Full instruction queue only with two instructions outstanding
      if (!req_ready_o && (accept_count - done_count) < 2) begin
        error_count++;
        $display("ERROR at %0t ns: req_ready_o low with fewer than two requests queued", $time);
      end
      if (req_valid_i && req_ready_o) begin
        req_q.push_back(req_i);
        done_ids.push_back(req_i.id);
        accept_count++;
      end
      if (operand_valid_i && operand_ready_o) begin
        op_q.push_back(operand_i);
      end
      operand_hold = operand_valid_i && !operand_ready_o;
      if (res_valid_o && res_ready_i) begin
        pend       = seen;
        pend_valid = 1'b1;
      end
      stall_prev = res_valid_o && !res_ready_i;
      held       = seen;

      while (req_q.size() > 0 && op_q.size() >= stream_words(req_q[0])) begin
        expand_instruction();
      end
      match_results();
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Operand stream and write-port ready
  // An offered operand word stays until the DUT takes it
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      operand_valid_i <= 1'b0;
      res_ready_i     <= 1'b0;
    end else begin
      if (!operand_hold) begin
        operand_valid_i <= ({$random(seed)} % 100) < valid_pct;
        operand_i       <= {$random(seed), $random(seed)};
      end
      res_ready_i <= ({$random(seed)} % 100) < ready_pct;
    end
  end

  // Random legal request
  // Negative selects mean a random choice
  task automatic make_request(input int op_sel, input int sew_sel,
                              output sldu_pkg::slide_req_t r);
    int sew;
    int vl;
    int max_vl;
    sew    = (sew_sel < 0) ? {$random(seed)} % 4 : sew_sel;
    max_vl = sldu_pkg::VregBytes >> sew;
    // Mostly short vectors, a full register now and then
    if ({$random(seed)} % 4 == 0) begin
      vl = max_vl;
    end else begin
      vl = 1 + {$random(seed)} % ((max_vl + 3) / 4);
    end
    r.op     = sldu_pkg::sldu_op_e'((op_sel < 0) ? {$random(seed)} % 2 : op_sel);
    r.vsew   = sldu_pkg::vsew_e'(sew);
    r.vl     = sldu_pkg::vlen_t'(vl);
    r.offset = sldu_pkg::vlen_t'({$random(seed)} % vl);
    r.vd     = sldu_pkg::vreg_t'({$random(seed)} % sldu_pkg::WordsPerVreg);
    // Ids cycle
    // At most five instructions are in flight
    r.id     = sldu_pkg::vid_t'(next_id);
    next_id++;
  endtask

  // Starts right after a rising edge and ends right after one
  task automatic issue_request(input int op_sel, input int sew_sel, input int gap);
    sldu_pkg::slide_req_t r;
    logic                 accepted;
    int                   waited;
    make_request(op_sel, sew_sel, r);
    req_i       <= r;
    req_valid_i <= 1'b1;
    accepted = 1'b0;
    waited   = 0;
    while (!accepted && waited < 4000) begin
      @(negedge clk_i);
      accepted = req_ready_o;
      waited++;
      @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
    if (!accepted) begin
      timeout_count++;
      $display("ERROR at %0t ns: request id %0d was not accepted in time", $time, r.id);
    end
    repeat (gap) @(posedge clk_i);
  endtask

  initial begin
    int waited;
    seed            = 78;
    error_count     = 0;
    check_count     = 0;
    timeout_count   = 0;
    word_count      = 0;
    accept_count    = 0;
    done_count      = 0;
    next_id         = 0;
    ready_pct       = 100;
    valid_pct       = 80;
    pend_valid      = 1'b0;
    stall_prev      = 1'b0;
    operand_hold    = 1'b0;
    rst_ni          = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    operand_i       = '0;
    operand_valid_i = 1'b0;
    res_ready_i     = 1'b0;

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Idle outputs out of reset
    @(negedge clk_i);
    compare_value("req_ready_o", req_ready_o, 1'b1);
    compare_value("operand_ready_o", operand_ready_o, 1'b0);
    compare_value("res_valid_o", res_valid_o, 1'b0);
    compare_value("done_o", done_o, 1'b0);
    @(posedge clk_i);

    // Slide up, then slide down, at every element width
    for (int op = 0; op < 2; op++) begin
      for (int sew = 0; sew < 4; sew++) begin
        for (int n = 0; n < 4; n++) begin
          if (timeout_count == 0) begin
            issue_request(op, sew, {$random(seed)} % 3);
          end
        end
      end
    end

    // Heavy write-port back-pressure
    ready_pct = 40;
    for (int n = 0; n < 16; n++) begin
      if (timeout_count == 0) begin
        issue_request(-1, -1, {$random(seed)} % 4);
      end
    end

    // Back-to-back requests
    ready_pct = 75;
    valid_pct = 90;
    for (int n = 0; n < 16; n++) begin
      if (timeout_count == 0) begin
        issue_request(-1, -1, 0);
      end
    end

    // Drain every outstanding instruction
    waited = 0;
    while (done_count < accept_count && waited < 8000) begin
      @(posedge clk_i);
      waited++;
    end
    if (done_count < accept_count) begin
      timeout_count++;
      $display("ERROR at %0t ns: instructions still outstanding at the end", $time);
    end
    repeat (2) @(posedge clk_i);
    if (act_q.size() != 0 || exp_q.size() != 0 || req_q.size() != 0 || op_q.size() != 0) begin
      error_count++;
      $display("ERROR: result words or operands left unmatched at the end");
    end

    $display("Checks %0d, errors %0d, timeouts %0d, words %0d, instructions %0d",
             check_count, error_count, timeout_count, word_count, done_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
